// File: design/clint_pkg.sv
package clint_pkg;

  // Bus and register widths
  localparam int addr_w  = 16;
  localparam int data_w  = 32;
  localparam int mtime_w = 64;
  localparam int msip_w  = 1;

  // Register map for a single hart
  localparam logic [addr_w-1:0] addr_msip        = 16'h0000;
  localparam logic [addr_w-1:0] addr_mtimecmp_lo = 16'h4000;
  localparam logic [addr_w-1:0] addr_mtimecmp_hi = 16'h4004;
  localparam logic [addr_w-1:0] addr_mtime_lo    = 16'hBFF8;
  localparam logic [addr_w-1:0] addr_mtime_hi    = 16'hBFFC;

  // Flops between the rtc_clk pin and the edge detector
  localparam int rtc_sync_stages = 2;

  // Request from the APB master
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [addr_w-1:0] paddr;
    logic [data_w-1:0] pwdata;
  } apb_req_t;

  // Response back to the master
  typedef struct packed {
    logic [data_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // Register selected by the decoded address
  typedef enum logic [2:0] {
    REG_NONE,
    REG_MSIP,
    REG_MTIMECMP_LO,
    REG_MTIMECMP_HI,
    REG_MTIME_LO,
    REG_MTIME_HI
  } reg_sel_e;

  // Half-word write command towards the compare register
  typedef struct packed {
    logic              wr_lo;
    logic              wr_hi;
    logic [data_w-1:0] wdata;
  } cmp_wr_t;

endpackage

// File: design/clint_apb_ctrl.sv
`timescale 1ns/1ps

module clint_apb_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  clint_pkg::apb_req_t            apb_req,
  output clint_pkg::apb_rsp_t            apb_rsp,
  input  logic [clint_pkg::mtime_w-1:0]  mtime,
  input  logic [clint_pkg::mtime_w-1:0]  mtimecmp,
  output clint_pkg::cmp_wr_t             cmp_wr,
  output logic                           soft_irq
);

  logic                           access;
  logic                           wr_access;
  logic                           rd_access;
  clint_pkg::reg_sel_e            reg_sel;
  logic [clint_pkg::msip_w-1:0]   msip;
  logic [clint_pkg::data_w-1:0]   rdata;

  // Every access completes in the cycle where psel and penable are both set
  assign access    = apb_req.psel && apb_req.penable;
  assign wr_access = access && apb_req.pwrite;
  assign rd_access = access && !apb_req.pwrite;

  // Address decode shared by the write steering and the read mux
  always_comb begin
    case (apb_req.paddr)
      clint_pkg::addr_msip:        reg_sel = clint_pkg::REG_MSIP;
      clint_pkg::addr_mtimecmp_lo: reg_sel = clint_pkg::REG_MTIMECMP_LO;
      clint_pkg::addr_mtimecmp_hi: reg_sel = clint_pkg::REG_MTIMECMP_HI;
      clint_pkg::addr_mtime_lo:    reg_sel = clint_pkg::REG_MTIME_LO;
      clint_pkg::addr_mtime_hi:    reg_sel = clint_pkg::REG_MTIME_HI;
      default:                     reg_sel = clint_pkg::REG_NONE;
    endcase
  end

  // Software interrupt pending bit
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msip <= '0;
    end else if (wr_access && reg_sel == clint_pkg::REG_MSIP) begin
      msip <= apb_req.pwdata[clint_pkg::msip_w-1:0];
    end
  end

  // The interrupt line lags msip by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      soft_irq <= 1'b0;
    end else begin
      soft_irq <= msip[0];
    end
  end

  // Only the compare register halves take writes because mtime is read-only
  always_comb begin
    cmp_wr.wr_lo = wr_access && (reg_sel == clint_pkg::REG_MTIMECMP_LO);
    cmp_wr.wr_hi = wr_access && (reg_sel == clint_pkg::REG_MTIMECMP_HI);
    cmp_wr.wdata = apb_req.pwdata;
  end

  // Read data is zero outside a read access and for unmapped addresses
  always_comb begin
    rdata = '0;
    if (rd_access) begin
      case (reg_sel)
        clint_pkg::REG_MSIP: begin
          rdata = {{(clint_pkg::data_w - clint_pkg::msip_w){1'b0}}, msip};
        end
        clint_pkg::REG_MTIMECMP_LO: begin
          rdata = mtimecmp[clint_pkg::data_w-1:0];
        end
        clint_pkg::REG_MTIMECMP_HI: begin
          rdata = mtimecmp[clint_pkg::mtime_w-1:clint_pkg::data_w];
        end
        clint_pkg::REG_MTIME_LO: begin
          rdata = mtime[clint_pkg::data_w-1:0];
        end
        clint_pkg::REG_MTIME_HI: begin
          rdata = mtime[clint_pkg::mtime_w-1:clint_pkg::data_w];
        end
        default: begin
          rdata = '0;
        end
      endcase
    end
  end

  // No wait states and no error responses
  always_comb begin
    apb_rsp.prdata  = rdata;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = 1'b0;
  end

endmodule

// File: design/clint_mtime.sv
`timescale 1ns/1ps

module clint_mtime (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rtc_clk,
  output logic [clint_pkg::mtime_w-1:0] mtime
);

  logic [clint_pkg::rtc_sync_stages-1:0] rtc_sync;
  logic                                  rtc_dly;
  logic                                  rtc_rise;

  // rtc_clk is asynchronous to clk, so bring it in through a flop chain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rtc_sync <= '0;
    end else begin
      rtc_sync <= {rtc_sync[clint_pkg::rtc_sync_stages-2:0], rtc_clk};
    end
  end

  // One extra flop holds the previous synchronized level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rtc_dly <= 1'b0;
    end else begin
      rtc_dly <= rtc_sync[clint_pkg::rtc_sync_stages-1];
    end
  end

  // Single-cycle pulse per rising edge of rtc_clk
  assign rtc_rise = rtc_sync[clint_pkg::rtc_sync_stages-1] && !rtc_dly;

  // Free-running counter that wraps from all ones back to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtime <= '0;
    end else if (rtc_rise) begin
      mtime <= mtime + 1'b1;
    end
  end

endmodule

// File: design/clint_timer_cmp.sv
`timescale 1ns/1ps

module clint_timer_cmp (
  input  logic                          clk,
  input  logic                          rst_n,
  input  clint_pkg::cmp_wr_t            cmp_wr,
  input  logic [clint_pkg::mtime_w-1:0] mtime,
  output logic [clint_pkg::mtime_w-1:0] mtimecmp,
  output logic                          timer_irq
);

  logic cmp_hit;

  // Resetting to all ones keeps the timer interrupt off until software
  // programs a real deadline
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mtimecmp <= '1;
    end else begin
      if (cmp_wr.wr_lo) begin
        mtimecmp[clint_pkg::data_w-1:0] <= cmp_wr.wdata;
      end
      if (cmp_wr.wr_hi) begin
        mtimecmp[clint_pkg::mtime_w-1:clint_pkg::data_w] <= cmp_wr.wdata;
      end
    end
  end

  // Unsigned 64-bit compare
  assign cmp_hit = (mtime >= mtimecmp);

  // Registered so the interrupt follows the compare by exactly one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer_irq <= 1'b0;
    end else begin
      timer_irq <= cmp_hit;
    end
  end

endmodule

// File: design/clint_top.sv
`timescale 1ns/1ps

module clint_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rtc_clk,
  input  clint_pkg::apb_req_t apb_req,
  output clint_pkg::apb_rsp_t apb_rsp,
  output logic                timer_irq,
  output logic                soft_irq
);

  logic [clint_pkg::mtime_w-1:0] mtime;
  logic [clint_pkg::mtime_w-1:0] mtimecmp;
  clint_pkg::cmp_wr_t            cmp_wr;

  // Bus decode, msip and the read mux
  clint_apb_ctrl u_apb_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .cmp_wr   (cmp_wr),
    .soft_irq (soft_irq)
  );

  // Time base driven by the slow real-time clock
  clint_mtime u_mtime (
    .clk     (clk),
    .rst_n   (rst_n),
    .rtc_clk (rtc_clk),
    .mtime   (mtime)
  );

  // Deadline register and timer interrupt
  clint_timer_cmp u_timer_cmp (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmp_wr    (cmp_wr),
    .mtime     (mtime),
    .mtimecmp  (mtimecmp),
    .timer_irq (timer_irq)
  );

endmodule

// File: dv/clint_asserts.sv
`timescale 1ns/1ps

module clint_asserts (
  input logic                          clk,
  input logic                          rst_n,
  input clint_pkg::apb_req_t           apb_req,
  input clint_pkg::apb_rsp_t           apb_rsp,
  input logic                          timer_irq,
  input logic                          soft_irq,
  input logic [clint_pkg::mtime_w-1:0] mtime,
  input logic [clint_pkg::mtime_w-1:0] mtimecmp
);

  int   err_cnt = 0;
  logic msip_wr;
  logic msip_model;

  // Last value written to bit 0 of the msip address
  assign msip_wr = apb_req.psel && apb_req.penable && apb_req.pwrite &&
                   (apb_req.paddr == clint_pkg::addr_msip);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      msip_model <= 1'b0;
    end else if (msip_wr) begin
      msip_model <= apb_req.pwdata[0];
    end
  end

  rsp_fixed: assert property (@(posedge clk) disable iff (!rst_n)
    apb_rsp.pready && !apb_rsp.pslverr)
    else begin
      $error("pready or pslverr left its fixed value");
      err_cnt++;
    end

  soft_irq_follows: assert property (@(posedge clk) disable iff (!rst_n)
    soft_irq == $past(msip_model))
    else begin
      $error("soft_irq does not follow the written msip bit");
      err_cnt++;
    end

  timer_irq_follows: assert property (@(posedge clk) disable iff (!rst_n)
    timer_irq == $past(mtime >= mtimecmp))
    else begin
      $error("timer_irq does not match the mtime compare");
      err_cnt++;
    end

  // The counter advances by at most one tick per clk cycle
  mtime_step: assert property (@(posedge clk) disable iff (!rst_n)
    (mtime == $past(mtime)) || (mtime == $past(mtime) + 1'b1))
    else begin
      $error("mtime changed by more than one");
      err_cnt++;
    end

  irq_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !soft_irq && !timer_irq)
    else begin
      $error("interrupt high in the first cycle after reset");
      err_cnt++;
    end

endmodule

bind clint_top clint_asserts u_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .apb_req   (apb_req),
  .apb_rsp   (apb_rsp),
  .timer_irq (timer_irq),
  .soft_irq  (soft_irq),
  .mtime     (mtime),
  .mtimecmp  (mtimecmp)
);

// File: dv/clint_tb.sv
`timescale 1ns/1ps

module clint_tb;

  localparam int          est_cycles     = 1500;
  localparam int          timeout_cycles = 2 * est_cycles + 1000;
  localparam logic [31:0] lcg_seed       = 32'hdabe_413b;
  localparam logic [15:0] addr_unmapped  = 16'h2000;

  logic                clk;
  logic                rst_n;
  logic                rtc_clk;
  clint_pkg::apb_req_t apb_req;
  clint_pkg::apb_rsp_t apb_rsp;
  logic                timer_irq;
  logic                soft_irq;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          rtc_rises;
  int          read_rises;

  clint_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .rtc_clk   (rtc_clk),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .timer_irq (timer_irq),
    .soft_irq  (soft_irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // rtc_clk runs at a tenth of the clk rate once reset is released
  initial begin
    rtc_clk = 1'b0;
    rtc_rises = 0;
    wait (rst_n === 1'b1);
    forever begin
      repeat (5) @(negedge clk);
      rtc_clk = ~rtc_clk;
      if (rtc_clk) begin
        rtc_rises++;
      end
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      report_failure();
    end
  endtask

  task automatic check_range(input string name, input logic [31:0] lo,
                             input logic [31:0] hi, input logic [31:0] act);
    if ($isunknown(act) || act < lo || act > hi) begin
      $display("FAIL t=%0t %s expected %h..%h actual %h", $time, name, lo, hi, act);
      report_failure();
    end
  endtask

  // Setup phase now, access phase at the next falling edge
  task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwdata  = '0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #1;
    data = apb_rsp.prdata;
    read_rises = rtc_rises;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] data;
    apb_read(addr, data);
    check_value(name, exp, data);
  endtask

  // mtime may trail the rise count by one while an edge is still in the synchronizer
  task automatic check_mtime_lo(input logic [31:0] act, input int rises);
    logic [31:0] lo;
    lo = (rises > 0) ? rises - 1 : 0;
    check_range("mtime_lo", lo, rises, act);
  endtask

  task automatic wait_timer_irq(input int limit);
    int n;
    n = 0;
    while (!timer_irq && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!timer_irq) begin
      $display("timer_irq did not rise within %0d cycles", limit);
      report_failure();
    end
  endtask

  task automatic test_reset_values();
    read_check(clint_pkg::addr_mtimecmp_lo, 32'hffff_ffff, "mtimecmp_lo");
    read_check(clint_pkg::addr_mtimecmp_hi, 32'hffff_ffff, "mtimecmp_hi");
    read_check(clint_pkg::addr_msip, 32'h0, "msip");
    check_value("timer_irq", 32'h0, {31'h0, timer_irq});
    check_value("soft_irq", 32'h0, {31'h0, soft_irq});
  endtask

  task automatic test_read_back();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    a = lcg_next();
    b = lcg_next();
    apb_write(clint_pkg::addr_mtimecmp_lo, a);
    read_check(clint_pkg::addr_mtimecmp_lo, a, "mtimecmp_lo");
    read_check(clint_pkg::addr_mtimecmp_hi, 32'hffff_ffff, "mtimecmp_hi");
    apb_write(clint_pkg::addr_mtimecmp_hi, b);
    read_check(clint_pkg::addr_mtimecmp_hi, b, "mtimecmp_hi");
    read_check(clint_pkg::addr_mtimecmp_lo, a, "mtimecmp_lo");
    apb_write(clint_pkg::addr_msip, lcg_next() | 32'h1);
    read_check(clint_pkg::addr_msip, 32'h1, "msip");
    apb_write(clint_pkg::addr_msip, lcg_next() & 32'hffff_fffe);
    read_check(clint_pkg::addr_msip, 32'h0, "msip");
    // mtime is read-only, so these writes must be ignored
    apb_write(clint_pkg::addr_mtime_lo, lcg_next());
    apb_write(clint_pkg::addr_mtime_hi, lcg_next());
    apb_read(clint_pkg::addr_mtime_lo, data);
    check_mtime_lo(data, read_rises);
    read_check(clint_pkg::addr_mtime_hi, 32'h0, "mtime_hi");
    apb_write(addr_unmapped, lcg_next());
    read_check(addr_unmapped, 32'h0, "unmapped");
    read_check(clint_pkg::addr_mtimecmp_lo, a, "mtimecmp_lo");
    read_check(clint_pkg::addr_mtimecmp_hi, b, "mtimecmp_hi");
    read_check(clint_pkg::addr_msip, 32'h0, "msip");
    apb_write(clint_pkg::addr_mtimecmp_hi, 32'hffff_ffff);
    apb_write(clint_pkg::addr_mtimecmp_lo, 32'hffff_ffff);
  endtask

  task automatic test_soft_irq();
    apb_write(clint_pkg::addr_msip, 32'h1);
    repeat (2) @(negedge clk);
    check_value("soft_irq", 32'h1, {31'h0, soft_irq});
    apb_write(clint_pkg::addr_msip, 32'h0);
    repeat (2) @(negedge clk);
    check_value("soft_irq", 32'h0, {31'h0, soft_irq});
  endtask

  task automatic test_mtime_count();
    logic [31:0] m1;
    logic [31:0] m2;
    int          r1;
    int          r2;
    apb_read(clint_pkg::addr_mtime_lo, m1);
    r1 = read_rises;
    check_mtime_lo(m1, r1);
    read_check(clint_pkg::addr_mtime_hi, 32'h0, "mtime_hi");
    repeat (120) @(negedge clk);
    apb_read(clint_pkg::addr_mtime_lo, m2);
    r2 = read_rises;
    check_mtime_lo(m2, r2);
    read_check(clint_pkg::addr_mtime_hi, 32'h0, "mtime_hi");
    check_range("mtime delta", r2 - r1 - 1, r2 - r1 + 1, m2 - m1);
  endtask

  task automatic test_timer_irq();
    logic [31:0] m;
    logic [31:0] data;
    apb_read(clint_pkg::addr_mtime_lo, m);
    apb_write(clint_pkg::addr_mtimecmp_lo, m + 32'd4);
    apb_write(clint_pkg::addr_mtimecmp_hi, 32'h0);
    repeat (2) @(negedge clk);
    check_value("timer_irq", 32'h0, {31'h0, timer_irq});
    wait_timer_irq(200);
    apb_read(clint_pkg::addr_mtime_lo, data);
    check_range("mtime_lo", m + 32'd4, m + 32'd5, data);
    // Raising the upper half puts the deadline far away again
    apb_write(clint_pkg::addr_mtimecmp_hi, 32'hffff_ffff);
    apb_write(clint_pkg::addr_mtimecmp_lo, 32'hffff_ffff);
    repeat (3) @(negedge clk);
    check_value("timer_irq", 32'h0, {31'h0, timer_irq});
    apb_read(clint_pkg::addr_mtime_lo, m);
    apb_write(clint_pkg::addr_mtimecmp_lo, m + 32'd500);
    apb_write(clint_pkg::addr_mtimecmp_hi, 32'h0);
    repeat (30) @(negedge clk);
    check_value("timer_irq", 32'h0, {31'h0, timer_irq});
    apb_write(clint_pkg::addr_mtimecmp_hi, 32'hffff_ffff);
    apb_write(clint_pkg::addr_mtimecmp_lo, 32'hffff_ffff);
  endtask

  // Watches the bound assertions and the cycle budget
  always @(negedge clk) begin
    cycle_cnt++;
    if (DUT.u_asserts.err_cnt != 0) begin
      $display("A bound assertion on the DUT failed");
      report_failure();
    end else if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      report_failure();
    end
  end

  initial begin
    rst_n = 1'b0;
    apb_req = '0;
    lcg_state = lcg_seed;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    test_reset_values();
    test_read_back();
    test_soft_irq();
    test_mtime_count();
    test_timer_irq();
    repeat (5) @(negedge clk);
    if (DUT.u_asserts.err_cnt != 0) begin
      $display("A bound assertion on the DUT failed");
      report_failure();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

// File: tb.f
design/clint_pkg.sv
design/clint_apb_ctrl.sv
design/clint_mtime.sv
design/clint_timer_cmp.sv
design/clint_top.sv
dv/clint_asserts.sv
dv/clint_tb.sv
